//--- list.f
src/sq_pkg.sv
src/sq_ctrl_if.sv
src/sq_capture_if.sv
src/sq_control.sv
src/sq_entry_array.sv
src/sq_capture.sv
src/sq_commit_port.sv
src/store_queue_top.sv
verification/store_queue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the store queue simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module store_queue_tb -o store_queue_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/store_queue_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

//--- src/sq_capture.sv
// Broadcast tag matcher
`timescale 1ns/10ps

module sq_capture #(
    parameter type payload_t = logic [31:0],
    parameter int  TAG_BITS  = 6,
    parameter int  WAYS      = 2,
    parameter int  SQ_DEPTH  = 8
) (
    input  logic [WAYS-1:0]                bus_valid,
    input  logic [WAYS-1:0][TAG_BITS-1:0]  bus_tag,
    input  payload_t [WAYS-1:0]            bus_payload,
    sq_capture_if.capture                  cap
);

    logic [SQ_DEPTH-1:0][WAYS-1:0] match;

    // every bus way against every waiting entry
    always_comb begin
        for (int e = 0; e < SQ_DEPTH; e++) begin
            for (int w = 0; w < WAYS; w++) begin
                match[e][w] = bus_valid[w] && cap.entry_pending[e]
                              && (bus_tag[w] == cap.entry_tag[e]);
            end
        end
    end

    // scan downward so the lowest matching way is the one kept
    always_comb begin
        for (int e = 0; e < SQ_DEPTH; e++) begin
            cap.hit[e]        = |match[e];
            cap.fill_value[e] = '0;
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (match[e][w]) begin
                    cap.fill_value[e] = bus_payload[w];
                end
            end
        end
    end

endmodule

//--- src/sq_capture_if.sv
// Entry array to capture unit link
`timescale 1ns/10ps

interface sq_capture_if #(
    parameter type payload_t = logic [31:0],
    parameter int  TAG_BITS  = 6,
    parameter int  SQ_DEPTH  = 8
);

    // per entry tag to compare against the bus
    logic [SQ_DEPTH-1:0][TAG_BITS-1:0] entry_tag;
    // entry valid and field still waiting
    logic [SQ_DEPTH-1:0]               entry_pending;

    logic [SQ_DEPTH-1:0]               hit;
    payload_t [SQ_DEPTH-1:0]           fill_value;

    modport array (
        output entry_tag,
        output entry_pending,
        input  hit,
        input  fill_value
    );

    modport capture (
        input  entry_tag,
        input  entry_pending,
        output hit,
        output fill_value
    );

endinterface

//--- src/sq_commit_port.sv
// Data-cache write port
`timescale 1ns/10ps

module sq_commit_port
    import sq_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    sq_ctrl_if.drain   ctrl,
    input  sq_head_t   head_entry,
    output logic       write_en,
    output addr_t      write_addr,
    output data_t      write_data,
    output mem_size_t  write_size
);

    // single-cycle pulse after each commit
    always_ff @(posedge clock) begin
        if (reset || ctrl.flush) begin
            write_en <= 1'b0;
        end else begin
            write_en <= ctrl.commit_fire;
        end
    end

    // head fields sampled before the array clears the slot
    always_ff @(posedge clock) begin
        if (ctrl.commit_fire) begin
            write_addr <= head_entry.addr;
            write_data <= head_entry.data;
            write_size <= head_entry.size;
        end
    end

endmodule

//--- src/sq_control.sv
// Store queue pointer control
`timescale 1ns/10ps

module sq_control #(
    parameter int WAYS     = 2,
    parameter int SQ_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          except,
    input  logic                          commit,
    input  logic [WAYS-1:0]               enable,
    sq_ctrl_if.control                    ctrl,
    output logic [$clog2(SQ_DEPTH):0]     num_free,
    output logic [$clog2(SQ_DEPTH)-1:0]   sq_head,
    output logic [$clog2(SQ_DEPTH)-1:0]   sq_tail
);

    localparam int IDX_BITS = $clog2(SQ_DEPTH);
    localparam int CNT_BITS = IDX_BITS + 1;

    logic [SQ_DEPTH-1:0]           head_oh;
    logic [SQ_DEPTH-1:0]           tail_oh;
    logic [WAYS:0][SQ_DEPTH-1:0]   tail_chain;
    logic [CNT_BITS-1:0]           num_disp;

    function automatic logic [SQ_DEPTH-1:0] rotl(input logic [SQ_DEPTH-1:0] v);
        return {v[SQ_DEPTH-2:0], v[SQ_DEPTH-1]};
    endfunction

    function automatic logic [IDX_BITS-1:0] to_idx(input logic [SQ_DEPTH-1:0] oh);
        logic [IDX_BITS-1:0] idx;
        idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (oh[i]) begin
                idx = idx | IDX_BITS'(i);
            end
        end
        return idx;
    endfunction

    // each enabled way takes the slot after the previous way's
    always_comb begin
        tail_chain[0] = tail_oh;
        num_disp      = '0;
        for (int w = 0; w < WAYS; w++) begin
            tail_chain[w+1]    = enable[w] ? rotl(tail_chain[w]) : tail_chain[w];
            ctrl.alloc_slot[w] = enable[w] ? tail_chain[w] : '0;
            num_disp           = num_disp + CNT_BITS'(enable[w]);
        end
    end

    // an exception overrides a commit in the same cycle
    assign ctrl.commit_fire = commit && !except;
    assign ctrl.flush       = except;
    assign ctrl.head_slot   = head_oh;

    always_ff @(posedge clock) begin
        if (reset || except) begin
            head_oh  <= SQ_DEPTH'(1);
            tail_oh  <= SQ_DEPTH'(1);
            num_free <= CNT_BITS'(SQ_DEPTH);
        end else begin
            if (ctrl.commit_fire) begin
                head_oh <= rotl(head_oh);
            end
            tail_oh  <= tail_chain[WAYS];
            num_free <= num_free - num_disp + CNT_BITS'(ctrl.commit_fire);
        end
    end

    // binary view for debug
    assign sq_head = to_idx(head_oh);
    assign sq_tail = to_idx(tail_oh);

endmodule

//--- src/sq_ctrl_if.sv
// Store queue control bundle
`timescale 1ns/10ps

interface sq_ctrl_if #(
    parameter int WAYS     = 2,
    parameter int SQ_DEPTH = 8
);

    // one-hot slot per dispatch way, zero when the way is idle
    logic [WAYS-1:0][SQ_DEPTH-1:0] alloc_slot;
    // one-hot head pointer
    logic [SQ_DEPTH-1:0]           head_slot;
    logic                          commit_fire;
    logic                          flush;

    modport control (
        output alloc_slot,
        output head_slot,
        output commit_fire,
        output flush
    );

    modport array (
        input alloc_slot,
        input head_slot,
        input commit_fire,
        input flush
    );

    modport drain (
        input head_slot,
        input commit_fire,
        input flush
    );

endinterface

//--- src/sq_entry_array.sv
// Store queue entry storage
`timescale 1ns/10ps

module sq_entry_array
    import sq_pkg::*;
#(
    parameter int WAYS      = 2,
    parameter int SQ_DEPTH  = 8,
    parameter int ROB_DEPTH = 32,
    parameter int PRF_DEPTH = 64
) (
    input  logic                                clock,
    input  logic                                reset,
    sq_ctrl_if.array                            ctrl,
    input  mem_size_t [WAYS-1:0]                size,
    input  data_t [WAYS-1:0]                    data,
    input  logic [WAYS-1:0]                     data_ready,
    input  logic [WAYS-1:0][$clog2(ROB_DEPTH)-1:0] rob_idx,
    sq_capture_if.array                         data_cap,
    sq_capture_if.array                         addr_cap,
    output sq_head_t                            head_entry
);

    localparam int ROB_BITS = $clog2(ROB_DEPTH);
    localparam int PRF_BITS = $clog2(PRF_DEPTH);

    // control flags
    logic [SQ_DEPTH-1:0]                valid;
    logic [SQ_DEPTH-1:0]                data_valid;
    logic [SQ_DEPTH-1:0]                addr_valid;

    // payload
    mem_size_t [SQ_DEPTH-1:0]           size_q;
    logic [SQ_DEPTH-1:0][ROB_BITS-1:0]  rob_q;
    data_t [SQ_DEPTH-1:0]               data_q;
    addr_t [SQ_DEPTH-1:0]               addr_q;

    // dispatch fields steered to their allocated slots
    logic [SQ_DEPTH-1:0]                alloc_any;
    logic [SQ_DEPTH-1:0]                alloc_ready;
    mem_size_t [SQ_DEPTH-1:0]           alloc_size;
    logic [SQ_DEPTH-1:0][ROB_BITS-1:0]  alloc_rob;
    data_t [SQ_DEPTH-1:0]               alloc_data;

    always_comb begin
        for (int e = 0; e < SQ_DEPTH; e++) begin
            alloc_any[e]   = 1'b0;
            alloc_ready[e] = 1'b0;
            alloc_size[e]  = MEM_BYTE;
            alloc_rob[e]   = '0;
            alloc_data[e]  = '0;
            for (int w = 0; w < WAYS; w++) begin
                if (ctrl.alloc_slot[w][e]) begin
                    alloc_any[e]   = 1'b1;
                    alloc_ready[e] = data_ready[w];
                    alloc_size[e]  = size[w];
                    alloc_rob[e]   = rob_idx[w];
                    alloc_data[e]  = data[w];
                end
            end
        end
    end

    // tags and pending flags for the two capture units
    always_comb begin
        for (int e = 0; e < SQ_DEPTH; e++) begin
            data_cap.entry_tag[e]     = data_q[e][PRF_BITS-1:0];
            data_cap.entry_pending[e] = valid[e] && !data_valid[e];
            addr_cap.entry_tag[e]     = rob_q[e];
            addr_cap.entry_pending[e] = valid[e] && !addr_valid[e];
        end
    end

    always_ff @(posedge clock) begin
        if (reset || ctrl.flush) begin
            valid      <= '0;
            data_valid <= '0;
            addr_valid <= '0;
        end else begin
            for (int e = 0; e < SQ_DEPTH; e++) begin
                if (alloc_any[e]) begin
                    valid[e]      <= 1'b1;
                    data_valid[e] <= alloc_ready[e];
                    addr_valid[e] <= 1'b0;
                end else if (ctrl.commit_fire && ctrl.head_slot[e]) begin
                    valid[e]      <= 1'b0;
                    data_valid[e] <= 1'b0;
                    addr_valid[e] <= 1'b0;
                end else begin
                    if (data_cap.hit[e]) begin
                        data_valid[e] <= 1'b1;
                    end
                    if (addr_cap.hit[e]) begin
                        addr_valid[e] <= 1'b1;
                    end
                end
            end
        end
    end

    // hits only land on valid entries, never on a slot being allocated
    always_ff @(posedge clock) begin
        for (int e = 0; e < SQ_DEPTH; e++) begin
            if (alloc_any[e]) begin
                size_q[e] <= alloc_size[e];
                rob_q[e]  <= alloc_rob[e];
                data_q[e] <= alloc_data[e];
            end else if (data_cap.hit[e]) begin
                data_q[e] <= data_cap.fill_value[e];
            end
            if (addr_cap.hit[e]) begin
                addr_q[e] <= addr_cap.fill_value[e];
            end
        end
    end

    // head select
    always_comb begin
        head_entry = '0;
        for (int e = 0; e < SQ_DEPTH; e++) begin
            if (ctrl.head_slot[e]) begin
                head_entry.size = size_q[e];
                head_entry.data = data_q[e];
                head_entry.addr = addr_q[e];
            end
        end
    end

endmodule

//--- src/sq_pkg.sv
// Store queue shared types
package sq_pkg;

    // access width of a store, as seen by the data cache
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    // store value
    // holds the producer's PRF tag in its low bits until the CDB fills it
    typedef logic [31:0] data_t;

    // store address
    typedef logic [15:0] addr_t;

    // fields of the head entry needed by the data-cache write port
    typedef struct packed {
        mem_size_t size;
        data_t     data;
        addr_t     addr;
    } sq_head_t;

endpackage

//--- src/store_queue_top.sv
// Store queue top level
`timescale 1ns/10ps

module store_queue_top
    import sq_pkg::*;
#(
    parameter int WAYS      = 2,
    parameter int SQ_DEPTH  = 8,
    parameter int ROB_DEPTH = 32,
    parameter int PRF_DEPTH = 64
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    except,
    input  logic                                    commit,
    // dispatch
    input  logic [WAYS-1:0]                         disp_enable,
    input  mem_size_t [WAYS-1:0]                    disp_size,
    input  data_t [WAYS-1:0]                        disp_data,
    input  logic [WAYS-1:0]                         disp_data_ready,
    input  logic [WAYS-1:0][$clog2(ROB_DEPTH)-1:0]  disp_rob_idx,
    // common data bus
    input  logic [WAYS-1:0]                         cdb_valid,
    input  logic [WAYS-1:0][$clog2(PRF_DEPTH)-1:0]  cdb_tag,
    input  data_t [WAYS-1:0]                        cdb_data,
    // address ALU
    input  logic [WAYS-1:0]                         alu_valid,
    input  logic [WAYS-1:0][$clog2(ROB_DEPTH)-1:0]  alu_rob_idx,
    input  addr_t [WAYS-1:0]                        alu_addr,
    // data cache
    output logic                                    write_en,
    output addr_t                                   write_addr,
    output data_t                                   write_data,
    output mem_size_t                               write_size,
    // stall logic and debug
    output logic [$clog2(SQ_DEPTH):0]               num_free,
    output logic [$clog2(SQ_DEPTH)-1:0]             sq_head,
    output logic [$clog2(SQ_DEPTH)-1:0]             sq_tail
);

    localparam int ROB_BITS = $clog2(ROB_DEPTH);
    localparam int PRF_BITS = $clog2(PRF_DEPTH);

    sq_head_t head_entry;

    sq_ctrl_if #(.WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH)) ctrl_if ();

    sq_capture_if #(
        .payload_t(data_t), .TAG_BITS(PRF_BITS), .SQ_DEPTH(SQ_DEPTH)
    ) data_cap_if ();

    sq_capture_if #(
        .payload_t(addr_t), .TAG_BITS(ROB_BITS), .SQ_DEPTH(SQ_DEPTH)
    ) addr_cap_if ();

    sq_control #(.WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH)) u_control (
        .clock    (clock),
        .reset    (reset),
        .except   (except),
        .commit   (commit),
        .enable   (disp_enable),
        .ctrl     (ctrl_if.control),
        .num_free (num_free),
        .sq_head  (sq_head),
        .sq_tail  (sq_tail)
    );

    sq_entry_array #(
        .WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH), .ROB_DEPTH(ROB_DEPTH), .PRF_DEPTH(PRF_DEPTH)
    ) u_entries (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl_if.array),
        .size       (disp_size),
        .data       (disp_data),
        .data_ready (disp_data_ready),
        .rob_idx    (disp_rob_idx),
        .data_cap   (data_cap_if.array),
        .addr_cap   (addr_cap_if.array),
        .head_entry (head_entry)
    );

    // CDB fills the data field, matched on the PRF tag
    sq_capture #(
        .payload_t(data_t), .TAG_BITS(PRF_BITS), .WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH)
    ) u_cdb_capture (
        .bus_valid   (cdb_valid),
        .bus_tag     (cdb_tag),
        .bus_payload (cdb_data),
        .cap         (data_cap_if.capture)
    );

    // address ALU fills the address, matched on the ROB index
    sq_capture #(
        .payload_t(addr_t), .TAG_BITS(ROB_BITS), .WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH)
    ) u_alu_capture (
        .bus_valid   (alu_valid),
        .bus_tag     (alu_rob_idx),
        .bus_payload (alu_addr),
        .cap         (addr_cap_if.capture)
    );

    sq_commit_port u_commit (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl_if.drain),
        .head_entry (head_entry),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_size (write_size)
    );

endmodule

//--- verification/store_queue_tb.sv
// Store queue testbench
`timescale 1ns/10ps

module store_queue_tb
    import sq_pkg::*;
();

    localparam int WAYS      = 2;
    localparam int SQ_DEPTH  = 8;
    localparam int ROB_DEPTH = 32;
    localparam int PRF_DEPTH = 64;
    localparam int IDX_BITS  = $clog2(SQ_DEPTH);
    localparam int CNT_BITS  = IDX_BITS + 1;
    localparam int ROB_BITS  = $clog2(ROB_DEPTH);
    localparam int PRF_BITS  = $clog2(PRF_DEPTH);

    // one cycle of stimulus and the outputs expected after its rising edge
    typedef struct packed {
        logic [WAYS-1:0]                en;
        mem_size_t [WAYS-1:0]           size;
        data_t [WAYS-1:0]               data;
        logic [WAYS-1:0]                ready;
        logic [WAYS-1:0][ROB_BITS-1:0]  rob;
        logic [WAYS-1:0]                cdb_valid;
        logic [WAYS-1:0][PRF_BITS-1:0]  cdb_tag;
        data_t [WAYS-1:0]               cdb_data;
        logic [WAYS-1:0]                alu_valid;
        logic [WAYS-1:0][ROB_BITS-1:0]  alu_rob;
        addr_t [WAYS-1:0]               alu_addr;
        logic                           commit;
        logic                           except;
        logic                           exp_wen;
        addr_t                          exp_addr;
        data_t                          exp_data;
        mem_size_t                      exp_size;
        logic [CNT_BITS-1:0]            exp_free;
        logic [IDX_BITS-1:0]            exp_head;
        logic [IDX_BITS-1:0]            exp_tail;
    } row_t;

    logic                           clock;
    logic                           reset;
    logic                           except;
    logic                           commit;
    logic [WAYS-1:0]                disp_enable;
    mem_size_t [WAYS-1:0]           disp_size;
    data_t [WAYS-1:0]               disp_data;
    logic [WAYS-1:0]                disp_data_ready;
    logic [WAYS-1:0][ROB_BITS-1:0]  disp_rob_idx;
    logic [WAYS-1:0]                cdb_valid;
    logic [WAYS-1:0][PRF_BITS-1:0]  cdb_tag;
    data_t [WAYS-1:0]               cdb_data;
    logic [WAYS-1:0]                alu_valid;
    logic [WAYS-1:0][ROB_BITS-1:0]  alu_rob_idx;
    addr_t [WAYS-1:0]               alu_addr;
    logic                           write_en;
    addr_t                          write_addr;
    data_t                          write_data;
    mem_size_t                      write_size;
    logic [CNT_BITS-1:0]            num_free;
    logic [IDX_BITS-1:0]            sq_head;
    logic [IDX_BITS-1:0]            sq_tail;

    row_t rows[$];
    row_t cur;
    int   model_free;
    int   model_head;
    int   model_tail;
    int   errors;
    int   seed = 32'h064be066;

    store_queue_top #(
        .WAYS(WAYS), .SQ_DEPTH(SQ_DEPTH), .ROB_DEPTH(ROB_DEPTH), .PRF_DEPTH(PRF_DEPTH)
    ) uut (
        .clock(clock), .reset(reset), .except(except), .commit(commit),
        .disp_enable(disp_enable), .disp_size(disp_size), .disp_data(disp_data),
        .disp_data_ready(disp_data_ready), .disp_rob_idx(disp_rob_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .alu_valid(alu_valid), .alu_rob_idx(alu_rob_idx), .alu_addr(alu_addr),
        .write_en(write_en), .write_addr(write_addr), .write_data(write_data),
        .write_size(write_size), .num_free(num_free), .sq_head(sq_head), .sq_tail(sq_tail)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic start_row();
        cur = '0;
    endtask

    task automatic dispatch_store(input int way, input mem_size_t size, input data_t value,
                                  input logic ready, input int rob);
        cur.en[way]    = 1'b1;
        cur.size[way]  = size;
        cur.data[way]  = value;
        cur.ready[way] = ready;
        cur.rob[way]   = ROB_BITS'(rob);
    endtask

    task automatic broadcast_cdb(input int way, input int tag, input data_t value);
        cur.cdb_valid[way] = 1'b1;
        cur.cdb_tag[way]   = PRF_BITS'(tag);
        cur.cdb_data[way]  = value;
    endtask

    task automatic deliver_addr(input int way, input int rob, input addr_t addr);
        cur.alu_valid[way] = 1'b1;
        cur.alu_rob[way]   = ROB_BITS'(rob);
        cur.alu_addr[way]  = addr;
    endtask

    // commit the head and expect its write one cycle later
    task automatic commit_head(input addr_t addr, input data_t value, input mem_size_t size);
        cur.commit   = 1'b1;
        cur.exp_wen  = 1'b1;
        cur.exp_addr = addr;
        cur.exp_data = value;
        cur.exp_size = size;
    endtask

    task automatic raise_except();
        cur.except = 1'b1;
    endtask

    // pointer and free count bookkeeping, then append the row
    task automatic finish_row();
        int n;
        n = 0;
        for (int w = 0; w < WAYS; w++) begin
            n = n + (cur.en[w] ? 1 : 0);
        end
        if (cur.except) begin
            model_free = SQ_DEPTH;
            model_head = 0;
            model_tail = 0;
            cur.exp_wen = 1'b0;
        end else begin
            model_head = (model_head + (cur.commit ? 1 : 0)) % SQ_DEPTH;
            model_tail = (model_tail + n) % SQ_DEPTH;
            model_free = model_free - n + (cur.commit ? 1 : 0);
        end
        cur.exp_free = CNT_BITS'(model_free);
        cur.exp_head = IDX_BITS'(model_head);
        cur.exp_tail = IDX_BITS'(model_tail);
        rows.push_back(cur);
    endtask

    task automatic idle_row();
        start_row();
        finish_row();
    endtask

    task automatic build_table();
        data_t     fill_data [SQ_DEPTH];
        addr_t     fill_addr [SQ_DEPTH];
        mem_size_t fill_size [SQ_DEPTH];
        model_free = SQ_DEPTH;
        model_head = 0;
        model_tail = 0;
        // state right after reset
        idle_row();
        // two stores in one cycle with addresses on swapped ALU ways
        start_row();
        dispatch_store(0, MEM_WORD, 32'h1111_aaaa, 1'b1, 3);
        dispatch_store(1, MEM_HALF, 32'h2222_bbbb, 1'b1, 4);
        finish_row();
        start_row();
        deliver_addr(0, 4, 16'h0200);
        deliver_addr(1, 3, 16'h0100);
        finish_row();
        start_row();
        commit_head(16'h0100, 32'h1111_aaaa, MEM_WORD);
        finish_row();
        start_row();
        commit_head(16'h0200, 32'h2222_bbbb, MEM_HALF);
        finish_row();
        idle_row();
        // data waiting on PRF tag 0x15
        start_row();
        dispatch_store(0, MEM_BYTE, 32'h0000_0015, 1'b0, 7);
        broadcast_cdb(0, 'h15, 32'hdead_0001);
        finish_row();
        start_row();
        broadcast_cdb(1, 'h16, 32'hdead_0002);
        deliver_addr(0, 7, 16'h0300);
        finish_row();
        start_row();
        broadcast_cdb(0, 'h15, 32'hcafe_f00d);
        finish_row();
        start_row();
        commit_head(16'h0300, 32'hcafe_f00d, MEM_BYTE);
        finish_row();
        // exception with three stores in flight
        start_row();
        dispatch_store(0, MEM_WORD, 32'h5555_0001, 1'b1, 20);
        dispatch_store(1, MEM_WORD, 32'h5555_0002, 1'b1, 21);
        finish_row();
        start_row();
        deliver_addr(0, 20, 16'h0500);
        deliver_addr(1, 21, 16'h0504);
        dispatch_store(0, MEM_BYTE, 32'h5555_0003, 1'b1, 22);
        finish_row();
        start_row();
        raise_except();
        // a commit raised with the exception must not reach the cache
        cur.commit = 1'b1;
        finish_row();
        idle_row();
        // fill all entries, then drain and wrap
        for (int i = 0; i < SQ_DEPTH; i++) begin
            fill_data[i] = $random(seed);
            fill_addr[i] = addr_t'(32'h1000 + i * 4);
            fill_size[i] = mem_size_t'(2'(i % 3));
        end
        for (int p = 0; p < SQ_DEPTH / 2; p++) begin
            start_row();
            dispatch_store(0, fill_size[2*p], fill_data[2*p], 1'b1, 8 + 2 * p);
            dispatch_store(1, fill_size[2*p+1], fill_data[2*p+1], 1'b1, 9 + 2 * p);
            if (p > 0) begin
                deliver_addr(0, 6 + 2 * p, fill_addr[2*p-2]);
                deliver_addr(1, 7 + 2 * p, fill_addr[2*p-1]);
            end
            finish_row();
        end
        start_row();
        deliver_addr(0, 6 + SQ_DEPTH, fill_addr[SQ_DEPTH-2]);
        deliver_addr(1, 7 + SQ_DEPTH, fill_addr[SQ_DEPTH-1]);
        finish_row();
        for (int i = 0; i < SQ_DEPTH; i++) begin
            start_row();
            commit_head(fill_addr[i], fill_data[i], fill_size[i]);
            finish_row();
        end
        // dispatch and commit together
        start_row();
        dispatch_store(0, MEM_WORD, 32'h6666_0001, 1'b1, 24);
        finish_row();
        start_row();
        deliver_addr(0, 24, 16'h0600);
        dispatch_store(0, MEM_HALF, 32'h6666_0002, 1'b1, 25);
        finish_row();
        start_row();
        commit_head(16'h0600, 32'h6666_0001, MEM_WORD);
        dispatch_store(0, MEM_WORD, 32'h6666_0003, 1'b1, 26);
        deliver_addr(0, 25, 16'h0604);
        finish_row();
        start_row();
        commit_head(16'h0604, 32'h6666_0002, MEM_HALF);
        deliver_addr(0, 26, 16'h0608);
        finish_row();
        start_row();
        commit_head(16'h0608, 32'h6666_0003, MEM_WORD);
        finish_row();
        idle_row();
    endtask

    task automatic apply_inputs(input row_t r);
        disp_enable     = r.en;
        disp_size       = r.size;
        disp_data       = r.data;
        disp_data_ready = r.ready;
        disp_rob_idx    = r.rob;
        cdb_valid       = r.cdb_valid;
        cdb_tag         = r.cdb_tag;
        cdb_data        = r.cdb_data;
        alu_valid       = r.alu_valid;
        alu_rob_idx     = r.alu_rob;
        alu_addr        = r.alu_addr;
        commit          = r.commit;
        except          = r.except;
    endtask

    task automatic report_mismatch(input string what, input int idx,
                                   input logic [31:0] got, input logic [31:0] expected);
        errors++;
        $display("error at %0d ns: row %0d %s is %h, expected %h",
                 $time, idx, what, got, expected);
    endtask

    task automatic check_outputs(input row_t r, input int idx);
        if (write_en !== r.exp_wen) begin
            report_mismatch("write_en", idx, 32'(write_en), 32'(r.exp_wen));
        end
        // address, data and size only mean something during a write
        if (r.exp_wen) begin
            if (write_addr !== r.exp_addr) begin
                report_mismatch("write_addr", idx, 32'(write_addr), 32'(r.exp_addr));
            end
            if (write_data !== r.exp_data) begin
                report_mismatch("write_data", idx, write_data, r.exp_data);
            end
            if (write_size !== r.exp_size) begin
                report_mismatch("write_size", idx, 32'(write_size), 32'(r.exp_size));
            end
        end
        if (num_free !== r.exp_free) begin
            report_mismatch("num_free", idx, 32'(num_free), 32'(r.exp_free));
        end
        if (sq_head !== r.exp_head) begin
            report_mismatch("sq_head", idx, 32'(sq_head), 32'(r.exp_head));
        end
        if (sq_tail !== r.exp_tail) begin
            report_mismatch("sq_tail", idx, 32'(sq_tail), 32'(r.exp_tail));
        end
    endtask

    initial begin
        errors = 0;
        reset  = 1'b1;
        apply_inputs('0);
        build_table();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_inputs(rows[i]);
            @(negedge clock);
            check_outputs(rows[i], i);
        end
        apply_inputs('0);
        $display("%0d rows checked, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // rows plus reset cycles, twice over
    initial begin : watchdog
        int limit;
        #1;
        limit = (rows.size() + 3) * 40 * 2;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule
